// File: rtl/microPkg.sv
package microPkg;

    // Microstate addresses, fixed by the microprogram layout
    typedef enum logic [6:0] {
        stReset   = 7'd0,
        stFetch   = 7'd1,
        stRead    = 7'd2,
        stLoadIr  = 7'd3,
        stDecode  = 7'd4,
        stAddu    = 7'd10,
        stSbAddr  = 7'd20,
        stSbData  = 7'd21,
        stSbWrite = 7'd22,
        stBeqCmp  = 7'd30,
        stBeqTake = 7'd31
    } stateT;

    // Condition source for the sequencer
    typedef enum logic [1:0] {
        condMoc,
        condCmp,
        condDmoc,
        condTrue
    } condSelT;

    // Next-address rule carried in each microword
    typedef enum logic [2:0] {
        nmIncrement,
        nmJump,
        nmDecode,
        nmFetch,
        nmCondJump,
        nmCondHold
    } nextModeT;

    // Select of the state mux
    typedef enum logic [1:0] {
        srcEncoder,
        srcFetch,
        srcTarget,
        srcIncrement
    } stateSrcT;

    typedef enum logic [1:0] {
        icAddu,
        icSb,
        icBeq,
        icOther
    } instrClassT;

    typedef struct packed {
        // Load strobes
        logic     irLd;
        logic     pcLd;
        logic     npcLd;
        logic     rfLd;
        logic     mdrLd;
        logic     marLd;
        logic     incRld;
        // Datapath mux selects
        logic       ma;
        logic [1:0] mb;
        logic       mc;
        logic       me;
        logic       mf;
        logic       mpa;
        logic       mp;
        logic       mr;
        // Memory control, rw high reads
        logic       rw;
        logic       memValid;
        // ALU and memory size fields
        logic [5:0] opC;
        logic       cin;
        logic [1:0] sse;
        logic [3:0] op;
        // Sequencing
        stateT      cr;
        logic       inv;
        condSelT    s;
        nextModeT   n;
    } microWordT;

    // All strobes off, back to fetch
    localparam microWordT idleWord = '{
        irLd: 1'b0, pcLd: 1'b0, npcLd: 1'b0, rfLd: 1'b0,
        mdrLd: 1'b0, marLd: 1'b0, incRld: 1'b0,
        ma: 1'b0, mb: 2'b00, mc: 1'b0, me: 1'b0, mf: 1'b0,
        mpa: 1'b0, mp: 1'b0, mr: 1'b0,
        rw: 1'b1, memValid: 1'b0,
        opC: 6'd0, cin: 1'b0, sse: 2'b00, op: 4'd0,
        cr: stReset, inv: 1'b0, s: condTrue, n: nmFetch
    };

endpackage

// File: rtl/opcodeEncoder.sv
`timescale 1ns/1ps

module opcodeEncoder (
    input  logic [31:0]     instruction,
    output microPkg::stateT entryState
);

    // Primary opcodes handled by the microprogram
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opBeq     = 6'h04,
        opSb      = 6'h28
    } opcodeT;

    // R-type function code for ADDU
    typedef enum logic [5:0] {
        fnAddu = 6'h21
    } functT;

    logic [5:0]           opcode;
    logic [5:0]           funct;
    microPkg::instrClassT instrClass;

    assign opcode = instruction[31:26];
    assign funct  = instruction[5:0];

    always_comb begin
        case (opcode)
            opSpecial: begin
                // Only ADDU among the R-type functions
                if (funct == fnAddu) begin
                    instrClass = microPkg::icAddu;
                end else begin
                    instrClass = microPkg::icOther;
                end
            end
            opSb:    instrClass = microPkg::icSb;
            opBeq:   instrClass = microPkg::icBeq;
            default: instrClass = microPkg::icOther;
        endcase
    end

    // Entry point of each microroutine
    always_comb begin
        unique case (instrClass)
            microPkg::icAddu:  entryState = microPkg::stAddu;
            microPkg::icSb:    entryState = microPkg::stSbAddr;
            microPkg::icBeq:   entryState = microPkg::stBeqCmp;
            microPkg::icOther: entryState = microPkg::stFetch;
        endcase
    end

endmodule

// File: rtl/nextStateSelect.sv
`timescale 1ns/1ps

module nextStateSelect (
    input  logic                MOV,
    input  logic                arstN,
    input  microPkg::microWordT ctrl,
    input  microPkg::stateT     entryState,
    input  logic                moc,
    input  logic                cond,
    input  logic                dmoc,
    output microPkg::stateT     nextState
);

    logic               condRaw;
    logic               condBit;
    microPkg::stateSrcT stateSrc;
    microPkg::stateT    incReg;

    // Condition mux
    always_comb begin
        unique case (ctrl.s)
            microPkg::condMoc:  condRaw = moc;
            microPkg::condCmp:  condRaw = cond;
            microPkg::condDmoc: condRaw = dmoc;
            microPkg::condTrue: condRaw = 1'b1;
        endcase
    end

    // Optional inversion of the selected condition
    assign condBit = condRaw ^ ctrl.inv;

    // Address-mode logic
    always_comb begin
        case (ctrl.n)
            microPkg::nmIncrement: stateSrc = microPkg::srcIncrement;
            microPkg::nmJump:      stateSrc = microPkg::srcTarget;
            microPkg::nmDecode:    stateSrc = microPkg::srcEncoder;
            microPkg::nmFetch:     stateSrc = microPkg::srcFetch;
            microPkg::nmCondJump: begin
                if (condBit) begin
                    stateSrc = microPkg::srcTarget;
                end else begin
                    stateSrc = microPkg::srcIncrement;
                end
            end
            microPkg::nmCondHold: begin
                // cr points back at the current state while waiting
                if (condBit) begin
                    stateSrc = microPkg::srcIncrement;
                end else begin
                    stateSrc = microPkg::srcTarget;
                end
            end
            default: stateSrc = microPkg::srcFetch;
        endcase
    end

    // State mux
    always_comb begin
        unique case (stateSrc)
            microPkg::srcEncoder:   nextState = entryState;
            microPkg::srcFetch:     nextState = microPkg::stFetch;
            microPkg::srcTarget:    nextState = ctrl.cr;
            microPkg::srcIncrement: nextState = incReg;
        endcase
    end

    // Incrementer register, loaded from the address going into the control register
    always_ff @(posedge MOV or negedge arstN) begin
        if (!arstN) begin
            incReg <= microPkg::stReset;
        end else if (ctrl.incRld) begin
            incReg <= microPkg::stateT'(nextState + 7'd1);
        end
    end

    // Mode and condition steering the state mux are never unknown out of reset
    srcKnown: assert property (
        @(posedge MOV) disable iff (!arstN)
        !$isunknown({ctrl.n, condBit})
    ) else $error("state source inputs unknown");

endmodule

// File: rtl/microstore.sv
`timescale 1ns/1ps

module microstore (
    input  microPkg::stateT     nextState,
    output microPkg::microWordT nextWord
);

    // ALU operation codes
    typedef enum logic [3:0] {
        aluAdd     = 4'b0000,
        aluPassA   = 4'b0001,
        aluCompare = 4'b1111
    } aluOpT;

    always_comb begin
        nextWord = microPkg::idleWord;
        case (nextState)
            microPkg::stReset: begin
                nextWord = microPkg::idleWord;
            end
            microPkg::stFetch: begin
                // MAR <- PC
                nextWord.marLd  = 1'b1;
                nextWord.incRld = 1'b1;
                nextWord.mpa    = 1'b1;
                nextWord.op     = aluPassA;
                nextWord.cr     = microPkg::stRead;
                nextWord.n      = microPkg::nmJump;
            end
            microPkg::stRead: begin
                nextWord.memValid = 1'b1;
                nextWord.rw       = 1'b1;
                nextWord.incRld   = 1'b1;
                nextWord.opC      = 6'h23;
                nextWord.cr       = microPkg::stRead;
                nextWord.s        = microPkg::condMoc;
                nextWord.n        = microPkg::nmCondHold;
            end
            microPkg::stLoadIr: begin
                // IR <- MDR, PC <- PC + 4
                nextWord.irLd   = 1'b1;
                nextWord.pcLd   = 1'b1;
                nextWord.incRld = 1'b1;
                nextWord.mpa    = 1'b1;
                nextWord.mb     = 2'b10;
                nextWord.mp     = 1'b1;
                nextWord.op     = aluAdd;
                nextWord.n      = microPkg::nmIncrement;
            end
            microPkg::stDecode: begin
                nextWord.incRld = 1'b1;
                nextWord.n      = microPkg::nmDecode;
            end
            microPkg::stAddu: begin
                // rd <- rs + rt
                nextWord.rfLd = 1'b1;
                nextWord.mc   = 1'b1;
                nextWord.mf   = 1'b1;
                nextWord.op   = aluAdd;
                nextWord.n    = microPkg::nmFetch;
            end
            microPkg::stSbAddr: begin
                // MAR <- rs + sign-extended offset
                nextWord.marLd  = 1'b1;
                nextWord.incRld = 1'b1;
                nextWord.mb     = 2'b01;
                nextWord.sse    = 2'b01;
                nextWord.op     = aluAdd;
                nextWord.n      = microPkg::nmIncrement;
            end
            microPkg::stSbData: begin
                // No incRld, so the incrementer keeps pointing at stSbWrite
                nextWord.mdrLd = 1'b1;
                nextWord.ma    = 1'b1;
                nextWord.me    = 1'b1;
                nextWord.op    = aluPassA;
                nextWord.n     = microPkg::nmIncrement;
            end
            microPkg::stSbWrite: begin
                // Byte store, stays here through the incrementer until moc
                nextWord.memValid = 1'b1;
                nextWord.rw       = 1'b0;
                nextWord.opC      = 6'h28;
                nextWord.mr       = 1'b1;
                nextWord.cr       = microPkg::stFetch;
                nextWord.s        = microPkg::condMoc;
                nextWord.n        = microPkg::nmCondJump;
            end
            microPkg::stBeqCmp: begin
                // Not equal jumps to fetch, equal falls through to stBeqTake
                nextWord.op  = aluCompare;
                nextWord.cin = 1'b1;
                nextWord.cr  = microPkg::stFetch;
                nextWord.inv = 1'b1;
                nextWord.s   = microPkg::condCmp;
                nextWord.n   = microPkg::nmCondJump;
            end
            microPkg::stBeqTake: begin
                // PC <- branch target
                nextWord.pcLd  = 1'b1;
                nextWord.npcLd = 1'b1;
                nextWord.sse   = 2'b10;
                nextWord.mb    = 2'b11;
                nextWord.op    = aluAdd;
                nextWord.n     = microPkg::nmFetch;
            end
            default: begin
                nextWord = microPkg::idleWord;
            end
        endcase
    end

endmodule

// File: rtl/controlRegister.sv
`timescale 1ns/1ps

module controlRegister (
    input  logic                MOV,
    input  logic                arstN,
    input  microPkg::microWordT nextWord,
    input  microPkg::stateT     nextState,
    output microPkg::microWordT ctrl,
    output microPkg::stateT     activeState
);

    always_ff @(posedge MOV or negedge arstN) begin
        if (!arstN) begin
            // Idle word carries nmFetch, so the first edge lands in stFetch
            ctrl        <= microPkg::idleWord;
            activeState <= microPkg::stReset;
        end else begin
            ctrl        <= nextWord;
            activeState <= nextState;
        end
    end

    // A memory cycle never overlaps a register-file write
    memRfExclusive: assert property (
        @(posedge MOV) disable iff (!arstN)
        !(ctrl.memValid && ctrl.rfLd)
    ) else $error("memValid and rfLd set together");

    // The sequencer only ever reaches states that have microcode
    namedState: assert property (
        @(posedge MOV) disable iff (!arstN)
        activeState inside {
            microPkg::stReset,
            microPkg::stFetch,
            microPkg::stRead,
            microPkg::stLoadIr,
            microPkg::stDecode,
            microPkg::stAddu,
            microPkg::stSbAddr,
            microPkg::stSbData,
            microPkg::stSbWrite,
            microPkg::stBeqCmp,
            microPkg::stBeqTake
        }
    ) else $error("activeState %0d has no microword", activeState);

endmodule

// File: rtl/microControlUnit.sv
`timescale 1ns/1ps

module microControlUnit (
    input  logic                MOV,
    input  logic                arstN,
    input  logic [31:0]         instruction,
    input  logic                moc,
    input  logic                cond,
    input  logic                dmoc,
    output microPkg::microWordT ctrl,
    output microPkg::stateT     activeState
);

    microPkg::stateT     entryState;
    microPkg::stateT     nextState;
    microPkg::microWordT nextWord;

    opcodeEncoder encoder (
        .instruction (instruction),
        .entryState  (entryState)
    );

    nextStateSelect select (
        .MOV        (MOV),
        .arstN      (arstN),
        .ctrl       (ctrl),
        .entryState (entryState),
        .moc        (moc),
        .cond       (cond),
        .dmoc       (dmoc),
        .nextState  (nextState)
    );

    microstore store (
        .nextState (nextState),
        .nextWord  (nextWord)
    );

    // Holds the active microword driven to the datapath
    controlRegister creg (
        .MOV         (MOV),
        .arstN       (arstN),
        .nextWord    (nextWord),
        .nextState   (nextState),
        .ctrl        (ctrl),
        .activeState (activeState)
    );

endmodule

// File: bench/microControlUnitTb.sv
`timescale 1ns/1ps

module microControlUnitTb;

    logic                MOV;
    logic                arstN;
    logic [31:0]         instruction;
    logic                moc;
    logic                cond;
    logic                dmoc;
    microPkg::microWordT ctrl;
    microPkg::stateT     activeState;

    int errorCount;
    int checkCount;
    int testCount;
    int latency;
    int waitCount;

    microControlUnit UUT (
        .MOV         (MOV),
        .arstN       (arstN),
        .instruction (instruction),
        .moc         (moc),
        .cond        (cond),
        .dmoc        (dmoc),
        .ctrl        (ctrl),
        .activeState (activeState)
    );

    initial begin
        MOV = 1'b0;
        forever #4 MOV = ~MOV;
    end

    // Memory model, moc rises latency cycles after memValid and drops once the access ends
    always @(posedge MOV) begin
        if (ctrl.memValid && !moc) begin
            if (waitCount + 1 >= latency) begin
                moc <= 1'b1;
            end
            waitCount <= waitCount + 1;
        end else begin
            moc       <= 1'b0;
            waitCount <= 0;
        end
    end

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic abortRun(input string what);
        $display("timeout: %s did not finish in time", what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic reportTest(input string name, input int startErrors);
        testCount++;
        $display("%s: finished with %0d errors", name, errorCount - startErrors);
    endtask

    // One full MOV cycle, ending where outputs are stable
    task automatic stepCycle();
        @(posedge MOV);
        @(negedge MOV);
    endtask

    // Datapath load strobes, irLd first
    function automatic logic [5:0] strobeBits(input microPkg::microWordT w);
        return {w.irLd, w.pcLd, w.npcLd, w.rfLd, w.mdrLd, w.marLd};
    endfunction

    task automatic expectWord(input microPkg::stateT st, input logic [5:0] strobes,
                              input logic memLevel, input string what);
        checkValue(activeState, st, {what, " state"});
        checkValue(strobeBits(ctrl), strobes, {what, " strobes"});
        checkValue(ctrl.memValid, memLevel, {what, " memValid"});
    endtask

    // Stays in a memory state while moc is low, counting the cycles
    task automatic holdOnMoc(input microPkg::stateT st, output int cycles);
        microPkg::microWordT heldWord;
        heldWord = ctrl;
        cycles   = 0;
        while (activeState == st) begin
            checkValue(ctrl, heldWord, "microword stable while holding");
            checkValue(ctrl.memValid, 1'b1, "memValid while holding");
            cycles++;
            if (cycles > 12) begin
                abortRun("memory wait");
            end
            stepCycle();
        end
    endtask

    // Fetch sequence from stFetch up to stDecode
    task automatic fetchInstruction(input logic [31:0] instr, input logic condLevel);
        int cycles;
        expectWord(microPkg::stFetch, 6'b000001, 1'b0, "fetch");
        latency = $urandom_range(4, 1);
        @(posedge MOV);
        instruction <= instr;
        cond        <= condLevel;
        @(negedge MOV);
        expectWord(microPkg::stRead, 6'b000000, 1'b1, "read");
        checkValue(ctrl.rw, 1'b1, "rw in read");
        holdOnMoc(microPkg::stRead, cycles);
        checkValue(cycles, latency + 1, "read cycles");
        expectWord(microPkg::stLoadIr, 6'b110000, 1'b0, "load IR");
        stepCycle();
        expectWord(microPkg::stDecode, 6'b000000, 1'b0, "decode");
    endtask

    task automatic testReset();
        int startErrors;
        startErrors = errorCount;
        repeat (4) begin
            @(negedge MOV);
            expectWord(microPkg::stReset, 6'b000000, 1'b0, "in reset");
            checkValue(ctrl.incRld, 1'b0, "in reset incRld");
        end
        @(posedge MOV);
        arstN <= 1'b1;
        @(negedge MOV);
        expectWord(microPkg::stReset, 6'b000000, 1'b0, "after release");
        checkValue(ctrl.incRld, 1'b0, "after release incRld");
        stepCycle();
        expectWord(microPkg::stFetch, 6'b000001, 1'b0, "first fetch");
        reportTest("reset", startErrors);
    endtask

    task automatic testFetch();
        int startErrors;
        startErrors = errorCount;
        // J opcode, not in the microprogram
        fetchInstruction({6'h02, 26'h0000100}, 1'b0);
        stepCycle();
        expectWord(microPkg::stFetch, 6'b000001, 1'b0, "fetch after jump");
        reportTest("fetch", startErrors);
    endtask

    task automatic testAddu();
        int startErrors;
        startErrors = errorCount;
        fetchInstruction({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h21}, 1'b0);
        stepCycle();
        expectWord(microPkg::stAddu, 6'b000100, 1'b0, "addu");
        stepCycle();
        expectWord(microPkg::stFetch, 6'b000001, 1'b0, "fetch after addu");
        reportTest("addu", startErrors);
    endtask

    task automatic testSb();
        int startErrors;
        int cycles;
        startErrors = errorCount;
        fetchInstruction({6'h28, 5'd4, 5'd5, 16'h0010}, 1'b0);
        stepCycle();
        expectWord(microPkg::stSbAddr, 6'b000001, 1'b0, "sb address");
        stepCycle();
        expectWord(microPkg::stSbData, 6'b000010, 1'b0, "sb data");
        latency = $urandom_range(4, 1);
        stepCycle();
        expectWord(microPkg::stSbWrite, 6'b000000, 1'b1, "sb write");
        checkValue(ctrl.rw, 1'b0, "rw in sb write");
        holdOnMoc(microPkg::stSbWrite, cycles);
        checkValue(cycles, latency + 1, "sb write cycles");
        expectWord(microPkg::stFetch, 6'b000001, 1'b0, "fetch after sb");
        reportTest("sb", startErrors);
    endtask

    task automatic runBeq(input logic taken);
        fetchInstruction({6'h04, 5'd6, 5'd7, 16'hfff0}, taken);
        stepCycle();
        expectWord(microPkg::stBeqCmp, 6'b000000, 1'b0, "beq compare");
        stepCycle();
        if (taken) begin
            expectWord(microPkg::stBeqTake, 6'b011000, 1'b0, "beq taken");
            stepCycle();
        end
        expectWord(microPkg::stFetch, 6'b000001, 1'b0, "fetch after beq");
    endtask

    task automatic testBeq();
        int startErrors;
        startErrors = errorCount;
        runBeq(1'b1);
        runBeq(1'b0);
        reportTest("beq", startErrors);
    endtask

    task automatic testUnknown();
        int          startErrors;
        logic [31:0] instrList [3];
        startErrors = errorCount;
        // LW, SUBU and an unused opcode
        instrList[0] = {6'h23, 5'd1, 5'd2, 16'h0004};
        instrList[1] = {6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h23};
        instrList[2] = {6'h3f, 26'h3ffffff};
        for (int i = 0; i < 3; i++) begin
            fetchInstruction(instrList[i], 1'b0);
            stepCycle();
            expectWord(microPkg::stFetch, 6'b000001, 1'b0, "fetch after unknown");
        end
        reportTest("unknown opcode", startErrors);
    endtask

    initial begin
        arstN       = 1'b0;
        instruction = 32'h0;
        moc         = 1'b0;
        cond        = 1'b0;
        dmoc        = 1'b0;
        errorCount  = 0;
        checkCount  = 0;
        testCount   = 0;
        latency     = 1;
        waitCount   = 0;
        void'($urandom(28));
        testReset();
        testFetch();
        testAddu();
        testSb();
        testBeq();
        testUnknown();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: microControlUnit.f
rtl/microPkg.sv
rtl/opcodeEncoder.sv
rtl/nextStateSelect.sv
rtl/microstore.sv
rtl/controlRegister.sv
rtl/microControlUnit.sv
bench/microControlUnitTb.sv

// File: Bender.yml
package:
  name: microControlUnit

sources:
  - rtl/microPkg.sv
  - rtl/opcodeEncoder.sv
  - rtl/nextStateSelect.sv
  - rtl/microstore.sv
  - rtl/controlRegister.sv
  - rtl/microControlUnit.sv
  - target: test
    files:
      - bench/microControlUnitTb.sv
